// File: Bender.yml
package:
  name: bbox_unit

sources:
  - files:
      - rtl/raster_pkg.sv
      - rtl/bbox_extent.sv
      - rtl/backface_cull.sv
      - rtl/bbox_snap_clip.sv
      - rtl/bbox_stage_regs.sv
      - rtl/bbox_unit.sv
  - target: test
    files:
      - verification/tb_bbox_unit.sv

// File: compile.f
rtl/raster_pkg.sv
rtl/bbox_extent.sv
rtl/backface_cull.sv
rtl/bbox_snap_clip.sv
rtl/bbox_stage_regs.sv
rtl/bbox_unit.sv
verification/tb_bbox_unit.sv

// File: rtl/backface_cull.sv
// Combinational winding test, flags counter-clockwise and degenerate triangles for discard
`timescale 1ns/100ps
`default_nettype none

module backface_cull import raster_pkg::*; (
    input  coord_t tri_x [NUM_VERTS],
    input  coord_t tri_y [NUM_VERTS],
    output logic   cull
);

    // One extra bit so the vertex differences never wrap
    localparam int EDGE_W  = SIGFIG + 1;
    // Products of two edges plus one bit for the final subtract
    localparam int CROSS_W = 2 * EDGE_W + 1;

    logic signed [EDGE_W-1:0]  edge0_x;
    logic signed [EDGE_W-1:0]  edge0_y;
    logic signed [EDGE_W-1:0]  edge1_x;
    logic signed [EDGE_W-1:0]  edge1_y;
    logic signed [CROSS_W-1:0] cross_z;

    // Edge from v0 to v1
    assign edge0_x = EDGE_W'(tri_x[1]) - EDGE_W'(tri_x[0]);
    assign edge0_y = EDGE_W'(tri_y[1]) - EDGE_W'(tri_y[0]);

    // Edge from v1 to v2
    assign edge1_x = EDGE_W'(tri_x[2]) - EDGE_W'(tri_x[1]);
    assign edge1_y = EDGE_W'(tri_y[2]) - EDGE_W'(tri_y[1]);

    // z part of edge0 x edge1, operands widened before the multiply
    assign cross_z = (CROSS_W'(edge0_x) * CROSS_W'(edge1_y))
                   - (CROSS_W'(edge0_y) * CROSS_W'(edge1_x));

    // Zero area or counter-clockwise winding gets dropped
    // Only a negative product survives
    assign cull = ~cross_z[CROSS_W-1];

endmodule

`default_nettype wire

// File: rtl/bbox_extent.sv
// Combinational min/max of the three triangle vertices per axis, giving the raw bounding box
`timescale 1ns/100ps
`default_nettype none

module bbox_extent import raster_pkg::*; (
    input  coord_t tri_x [NUM_VERTS],
    input  coord_t tri_y [NUM_VERTS],
    output coord_t ll_x,
    output coord_t ll_y,
    output coord_t ur_x,
    output coord_t ur_y
);

    // Both axes side by side, index 0 is x and 1 is y
    coord_t axis_v   [2][NUM_VERTS];
    coord_t axis_min [2];
    coord_t axis_max [2];

    assign axis_v[0] = tri_x;
    assign axis_v[1] = tri_y;

    for (genvar a = 0; a < 2; a++) begin : g_axis
        logic le01;
        logic le02;
        logic le12;
        logic [2:0] min_sel;
        logic [2:0] max_sel;

        // Three signed compares shared by min and max
        assign le01 = axis_v[a][0] <= axis_v[a][1];
        assign le02 = axis_v[a][0] <= axis_v[a][2];
        assign le12 = axis_v[a][1] <= axis_v[a][2];

        // One-hot pick of the smallest, equal values go to the lower vertex
        assign min_sel[0] = le01 & le02;
        assign min_sel[1] = ~le01 & le12;
        assign min_sel[2] = ~min_sel[0] & ~min_sel[1];

        // One-hot pick of the largest
        assign max_sel[2] = le02 & le12;
        assign max_sel[1] = le01 & ~le12;
        assign max_sel[0] = ~max_sel[2] & ~max_sel[1];

        // AND-OR mux over the select bits
        assign axis_min[a] = ({SIGFIG{min_sel[0]}} & axis_v[a][0])
                           | ({SIGFIG{min_sel[1]}} & axis_v[a][1])
                           | ({SIGFIG{min_sel[2]}} & axis_v[a][2]);
        assign axis_max[a] = ({SIGFIG{max_sel[0]}} & axis_v[a][0])
                           | ({SIGFIG{max_sel[1]}} & axis_v[a][1])
                           | ({SIGFIG{max_sel[2]}} & axis_v[a][2]);
    end

    assign ll_x = axis_min[0];
    assign ll_y = axis_min[1];
    assign ur_x = axis_max[0];
    assign ur_y = axis_max[1];

endmodule

`default_nettype wire

// File: rtl/bbox_snap_clip.sv
// Combinational snap of the raw box to the sample grid, screen clamp and accept/reject decision
`timescale 1ns/100ps
`default_nettype none

module bbox_snap_clip import raster_pkg::*; (
    input  coord_t     ll_x,
    input  coord_t     ll_y,
    input  coord_t     ur_x,
    input  coord_t     ur_y,
    input  coord_t     screen_x,
    input  coord_t     screen_y,
    input  msaa_mode_e msaa_mode,
    input  logic       tri_valid,
    input  logic       cull,
    output coord_t     clip_ll_x,
    output coord_t     clip_ll_y,
    output coord_t     clip_ur_x,
    output coord_t     clip_ur_y,
    output logic       valid
);

    // Fraction bits kept for the current sample step
    logic [RADIX-1:0] frac_mask;

    coord_t snap_ll_x;
    coord_t snap_ll_y;
    coord_t snap_ur_x;
    coord_t snap_ur_y;

    // Finer grids keep more of the upper fraction bits
    always_comb begin
        case (msaa_mode)
            MSAA_1X:  frac_mask = {RADIX{1'b0}};
            MSAA_4X:  frac_mask = {1'b1, {(RADIX-1){1'b0}}};
            MSAA_16X: frac_mask = {2'b11, {(RADIX-2){1'b0}}};
            MSAA_64X: frac_mask = {3'b111, {(RADIX-3){1'b0}}};
            // Unknown code falls back to whole pixels
            default:  frac_mask = {RADIX{1'b0}};
        endcase
    end

    // Integer part passes, low fraction bits cleared
    // Two's complement makes this a floor for negative values too
    assign snap_ll_x = {ll_x[SIGFIG-1:RADIX], ll_x[RADIX-1:0] & frac_mask};
    assign snap_ll_y = {ll_y[SIGFIG-1:RADIX], ll_y[RADIX-1:0] & frac_mask};
    assign snap_ur_x = {ur_x[SIGFIG-1:RADIX], ur_x[RADIX-1:0] & frac_mask};
    assign snap_ur_y = {ur_y[SIGFIG-1:RADIX], ur_y[RADIX-1:0] & frac_mask};

    // Lower left below or left of the origin pulls in to 0
    assign clip_ll_x = snap_ll_x[SIGFIG-1] ? '0 : snap_ll_x;
    assign clip_ll_y = snap_ll_y[SIGFIG-1] ? '0 : snap_ll_y;

    // Upper right past the screen edge pulls in to the edge
    assign clip_ur_x = (snap_ur_x > screen_x) ? screen_x : snap_ur_x;
    assign clip_ur_y = (snap_ur_y > screen_y) ? screen_y : snap_ur_y;

    // Reject when the box starts beyond the screen or ends before the origin
    // Culled and empty slots are rejected as well
    assign valid = tri_valid
                 & ~cull
                 & (snap_ll_x <= screen_x)
                 & (snap_ll_y <= screen_y)
                 & ~snap_ur_x[SIGFIG-1]
                 & ~snap_ur_y[SIGFIG-1];

endmodule

`default_nettype wire

// File: rtl/bbox_stage_regs.sv
// Stallable shift chain of PIPE_DEPTH stages carrying valid, clipped box and vertices downstream
`timescale 1ns/100ps
`default_nettype none

module bbox_stage_regs import raster_pkg::*; #(
    parameter int PIPE_DEPTH = 3
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   halt,
    input  logic   in_valid,
    input  coord_t in_x [NUM_VERTS],
    input  coord_t in_y [NUM_VERTS],
    input  coord_t in_box_ll_x,
    input  coord_t in_box_ll_y,
    input  coord_t in_box_ur_x,
    input  coord_t in_box_ur_y,
    output logic   out_valid,
    output coord_t out_x [NUM_VERTS],
    output coord_t out_y [NUM_VERTS],
    output coord_t out_box_ll_x,
    output coord_t out_box_ll_y,
    output coord_t out_box_ur_x,
    output coord_t out_box_ur_y
);

    // Stage 0 is nearest the input
    logic   valid_q [PIPE_DEPTH];
    coord_t x_q     [PIPE_DEPTH][NUM_VERTS];
    coord_t y_q     [PIPE_DEPTH][NUM_VERTS];
    // Corners in the order ll_x, ll_y, ur_x, ur_y
    coord_t box_q   [PIPE_DEPTH][4];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < PIPE_DEPTH; s++) begin
                valid_q[s] <= 1'b0;
                x_q[s]     <= '{default: '0};
                y_q[s]     <= '{default: '0};
                box_q[s]   <= '{default: '0};
            end
        end else if (!halt) begin
            // Head of the chain takes the current result
            valid_q[0] <= in_valid;
            x_q[0]     <= in_x;
            y_q[0]     <= in_y;
            box_q[0]   <= '{in_box_ll_x, in_box_ll_y, in_box_ur_x, in_box_ur_y};
            // Every later stage takes its predecessor
            for (int s = 1; s < PIPE_DEPTH; s++) begin
                valid_q[s] <= valid_q[s-1];
                x_q[s]     <= x_q[s-1];
                y_q[s]     <= y_q[s-1];
                box_q[s]   <= box_q[s-1];
            end
        end
    end

    // Tail stage drives the outputs
    assign out_valid    = valid_q[PIPE_DEPTH-1];
    assign out_x        = x_q[PIPE_DEPTH-1];
    assign out_y        = y_q[PIPE_DEPTH-1];
    assign out_box_ll_x = box_q[PIPE_DEPTH-1][0];
    assign out_box_ll_y = box_q[PIPE_DEPTH-1][1];
    assign out_box_ur_x = box_q[PIPE_DEPTH-1][2];
    assign out_box_ur_y = box_q[PIPE_DEPTH-1][3];

endmodule

`default_nettype wire

// File: rtl/bbox_unit.sv
// Bounding-box stage top level, combinational box logic feeding a stallable register chain
`timescale 1ns/100ps
`default_nettype none

module bbox_unit import raster_pkg::*; #(
    // Register stages between input and output, 1 or more
    parameter int PIPE_DEPTH = 3
) (
    input  logic       clk,
    input  logic       reset,
    // Triangle in
    input  coord_t     tri_x [NUM_VERTS],
    input  coord_t     tri_y [NUM_VERTS],
    input  logic       tri_valid,
    // Configuration, held steady while triangles arrive
    input  coord_t     screen_x,
    input  coord_t     screen_y,
    input  msaa_mode_e msaa_mode,
    // High freezes the whole stage
    input  logic       halt,
    // Delayed vertices
    output coord_t     out_x [NUM_VERTS],
    output coord_t     out_y [NUM_VERTS],
    // Clipped box
    output coord_t     box_ll_x,
    output coord_t     box_ll_y,
    output coord_t     box_ur_x,
    output coord_t     box_ur_y,
    output logic       box_valid
);

    // Raw box from the min/max search
    coord_t raw_ll_x;
    coord_t raw_ll_y;
    coord_t raw_ur_x;
    coord_t raw_ur_y;

    logic   cull;

    // Snapped and clamped box ahead of the registers
    coord_t clip_ll_x;
    coord_t clip_ll_y;
    coord_t clip_ur_x;
    coord_t clip_ur_y;
    logic   stage_valid;

    bbox_extent bbox_extent_inst (
        .tri_x (tri_x),
        .tri_y (tri_y),
        .ll_x  (raw_ll_x),
        .ll_y  (raw_ll_y),
        .ur_x  (raw_ur_x),
        .ur_y  (raw_ur_y)
    );

    backface_cull backface_cull_inst (
        .tri_x (tri_x),
        .tri_y (tri_y),
        .cull  (cull)
    );

    bbox_snap_clip bbox_snap_clip_inst (
        .ll_x      (raw_ll_x),
        .ll_y      (raw_ll_y),
        .ur_x      (raw_ur_x),
        .ur_y      (raw_ur_y),
        .screen_x  (screen_x),
        .screen_y  (screen_y),
        .msaa_mode (msaa_mode),
        .tri_valid (tri_valid),
        .cull      (cull),
        .clip_ll_x (clip_ll_x),
        .clip_ll_y (clip_ll_y),
        .clip_ur_x (clip_ur_x),
        .clip_ur_y (clip_ur_y),
        .valid     (stage_valid)
    );

    // Vertices ride alongside the box so both leave together
    bbox_stage_regs #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) bbox_stage_regs_inst (
        .clk          (clk),
        .reset        (reset),
        .halt         (halt),
        .in_valid     (stage_valid),
        .in_x         (tri_x),
        .in_y         (tri_y),
        .in_box_ll_x  (clip_ll_x),
        .in_box_ll_y  (clip_ll_y),
        .in_box_ur_x  (clip_ur_x),
        .in_box_ur_y  (clip_ur_y),
        .out_valid    (box_valid),
        .out_x        (out_x),
        .out_y        (out_y),
        .out_box_ll_x (box_ll_x),
        .out_box_ll_y (box_ll_y),
        .out_box_ur_x (box_ur_x),
        .out_box_ur_y (box_ur_y)
    );

endmodule

`default_nettype wire

// File: rtl/raster_pkg.sv
// Shared fixed-point coordinate format and multisample mode codes, imported by every RTL file
`default_nettype none

package raster_pkg;

    // Total bits in one coordinate
    localparam int SIGFIG = 24;

    // Fraction bits, the integer part sits above them
    localparam int RADIX = 10;

    // Vertices per triangle
    localparam int NUM_VERTS = 3;

    // Signed fixed point, 14 integer bits over 10 fraction bits
    typedef logic signed [SIGFIG-1:0] coord_t;

    // One-hot multisample mode
    // Sample step is 1, 1/2, 1/4 and 1/8 pixel
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000,
        MSAA_4X  = 4'b0100,
        MSAA_16X = 4'b0010,
        MSAA_64X = 4'b0001
    } msaa_mode_e;

endpackage

`default_nettype wire

// File: verification/bbox_cases.txt
# x0 x1 x2 y0 y1 y2 screen_x screen_y msaa tri_valid exp_valid ll_x ll_y ur_x ur_y
# All hex, coordinates in signed 14.10 fixed point, msaa is the one-hot mode code
002B00 002B00 00CA66 005155 00A399 005155 0A0000 078000 8 1 1 002800 005000 00C800 00A000
002B00 002B00 00CA66 005155 00A399 005155 0A0000 078000 4 1 1 002A00 005000 00CA00 00A200
002B00 002B00 00CA66 005155 00A399 005155 0A0000 078000 2 1 1 002B00 005100 00CA00 00A300
002B00 002B00 00CA66 005155 00A399 005155 0A0000 078000 1 1 1 002B00 005100 00CA00 00A380
FFEA00 FFEA00 0AF000 FFF300 07D000 FFF300 0A0000 078000 8 1 1 000000 000000 0A0000 078000
002B00 002B00 00CA66 005155 00A399 005155 0A0000 078000 8 0 0 000000 000000 000000 000000
002B00 00CA66 002B00 005155 005155 00A399 0A0000 078000 8 1 0 000000 000000 000000 000000
001000 002000 003000 001000 002000 003000 0A0000 078000 8 1 0 000000 000000 000000 000000
0AF000 0AF000 0B4000 002800 005000 002800 0A0000 078000 8 1 0 000000 000000 000000 000000
002800 002800 005000 07A800 07BC00 07A800 0A0000 078000 8 1 0 000000 000000 000000 000000
FF8800 FF8800 FFD800 002800 005000 002800 0A0000 078000 8 1 0 000000 000000 000000 000000
002800 002800 005000 FF8800 FFD800 FF8800 0A0000 078000 8 1 0 000000 000000 000000 000000
019080 04B380 019080 064040 032200 032200 0A0000 078000 2 1 1 019000 032200 04B300 064000
04B380 019080 019080 032200 032200 064040 0A0000 078000 1 1 1 019080 032200 04B380 064000
019080 019080 04B380 032200 064040 032200 0A0000 078000 4 1 1 019000 032200 04B200 064000
096000 096000 0A0200 06E000 078000 06E000 0A0000 078000 8 1 1 096000 06E000 0A0000 078000

// File: verification/tb_bbox_unit.sv
// Self-checking testbench for bbox_unit that replays the case file under random halts
`timescale 1ns/100ps
`default_nettype none

module tb_bbox_unit import raster_pkg::*; ();

    localparam int PIPE_DEPTH = 3;
    localparam int MAX_CASES  = 64;

    logic       clk;
    logic       reset;
    coord_t     tri_x [NUM_VERTS];
    coord_t     tri_y [NUM_VERTS];
    logic       tri_valid;
    coord_t     screen_x;
    coord_t     screen_y;
    msaa_mode_e msaa_mode;
    logic       halt;
    coord_t     out_x [NUM_VERTS];
    coord_t     out_y [NUM_VERTS];
    coord_t     box_ll_x;
    coord_t     box_ll_y;
    coord_t     box_ur_x;
    coord_t     box_ur_y;
    logic       box_valid;

    // Case table as read from the data file
    coord_t     case_x    [MAX_CASES][NUM_VERTS];
    coord_t     case_y    [MAX_CASES][NUM_VERTS];
    coord_t     case_sx   [MAX_CASES];
    coord_t     case_sy   [MAX_CASES];
    logic [3:0] case_msaa [MAX_CASES];
    logic       case_tv   [MAX_CASES];
    logic       case_ev   [MAX_CASES];
    // Expected corners ll_x, ll_y, ur_x, ur_y
    coord_t     case_box  [MAX_CASES][4];
    int         num_cases;

    // Case index held by each register stage
    // An empty slot holds -1
    int         model_q [$];
    int         cur_idx;
    int         seen_cases;
    int         last_seen;
    int         cycle_count;
    int         cycle_limit;
    int         seed;

    bbox_unit #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) bbox_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .tri_x     (tri_x),
        .tri_y     (tri_y),
        .tri_valid (tri_valid),
        .screen_x  (screen_x),
        .screen_y  (screen_y),
        .msaa_mode (msaa_mode),
        .halt      (halt),
        .out_x     (out_x),
        .out_y     (out_y),
        .box_ll_x  (box_ll_x),
        .box_ll_y  (box_ll_y),
        .box_ur_x  (box_ur_x),
        .box_ur_y  (box_ur_y),
        .box_valid (box_valid)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(string name, logic [SIGFIG-1:0] actual,
                               logic [SIGFIG-1:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic load_cases();
        int fd;
        int n;
        string line;
        logic [SIGFIG-1:0] f [15];
        num_cases = 0;
        fd = $fopen("verification/bbox_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file verification/bbox_cases.txt");
            stop_on_failure();
        end else begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                n = $fgets(line, fd);
                // Lines starting with a hash are column notes
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                    if (n == 15) begin
                        case_x[num_cases]    = '{f[0], f[1], f[2]};
                        case_y[num_cases]    = '{f[3], f[4], f[5]};
                        case_sx[num_cases]   = f[6];
                        case_sy[num_cases]   = f[7];
                        case_msaa[num_cases] = f[8][3:0];
                        case_tv[num_cases]   = f[9][0];
                        case_ev[num_cases]   = f[10][0];
                        case_box[num_cases]  = '{f[11], f[12], f[13], f[14]};
                        num_cases++;
                    end
                end
            end
            $fclose(fd);
            if (num_cases == 0) begin
                $display("The case file holds no usable cases");
                stop_on_failure();
            end
        end
    endtask

    // One triangle with halt low
    task automatic drive_case(int idx);
        tri_x     = case_x[idx];
        tri_y     = case_y[idx];
        tri_valid = case_tv[idx];
        screen_x  = case_sx[idx];
        screen_y  = case_sy[idx];
        msaa_mode = msaa_mode_e'(case_msaa[idx]);
        cur_idx   = idx;
        halt      = 1'b0;
    endtask

    // Empty slot that leaves the configuration as it was
    task automatic drive_idle();
        tri_x     = '{default: '0};
        tri_y     = '{default: '0};
        tri_valid = 1'b0;
        cur_idx   = -1;
        halt      = 1'b0;
    endtask

    // Zero to two stalled cycles with the inputs held
    task automatic hold_random();
        int n;
        n = $unsigned($random(seed)) % 3;
        if (n > 0) begin
            halt = 1'b1;
            repeat (n) @(negedge clk);
        end
    endtask

    // Reference chain that shifts only on edges the DUT takes
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            stop_on_failure();
        end else if (reset) begin
            model_q.delete();
            repeat (PIPE_DEPTH) model_q.push_back(-1);
        end else if (!halt) begin
            model_q.push_back(cur_idx);
            void'(model_q.pop_front());
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        int     idx;
        logic   exp_valid;
        coord_t exp_x [NUM_VERTS];
        coord_t exp_y [NUM_VERTS];
        if (model_q.size() == PIPE_DEPTH) begin
            idx = model_q[0];
            if (idx < 0) begin
                exp_valid = 1'b0;
                exp_x     = '{default: '0};
                exp_y     = '{default: '0};
            end else begin
                exp_valid = case_ev[idx];
                exp_x     = case_x[idx];
                exp_y     = case_y[idx];
            end
            // Count each case once as it reaches the outputs
            if (idx > last_seen) begin
                seen_cases++;
                last_seen = idx;
            end
            check_value("box_valid", box_valid, exp_valid);
            for (int v = 0; v < NUM_VERTS; v++) begin
                check_value($sformatf("out_x[%0d]", v), out_x[v], exp_x[v]);
                check_value($sformatf("out_y[%0d]", v), out_y[v], exp_y[v]);
            end
            // Corners only matter for accepted triangles
            if (exp_valid) begin
                check_value("box_ll_x", box_ll_x, case_box[idx][0]);
                check_value("box_ll_y", box_ll_y, case_box[idx][1]);
                check_value("box_ur_x", box_ur_x, case_box[idx][2]);
                check_value("box_ur_y", box_ur_y, case_box[idx][3]);
            end
        end
    end

    initial begin
        seed        = 95648;
        reset       = 1'b1;
        screen_x    = '0;
        screen_y    = '0;
        msaa_mode   = MSAA_1X;
        cycle_count = 0;
        seen_cases  = 0;
        last_seen   = -1;
        drive_idle();
        load_cases();
        cycle_limit = num_cases * 8 + PIPE_DEPTH + 50;
        // Reset for 5 cycles and release on a falling edge
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_cases; i++) begin
            drive_case(i);
            @(negedge clk);
            hold_random();
        end
        // Flush the chain with empty slots while stalls still occur
        for (int d = 0; d < PIPE_DEPTH; d++) begin
            drive_idle();
            @(negedge clk);
            hold_random();
        end
        @(posedge clk);
        if (seen_cases != num_cases) begin
            $display("Only %0d of %0d cases reached the outputs", seen_cases, num_cases);
            stop_on_failure();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
